/* list.f */
logic/writeback_pkg.sv
logic/load_aligner.sv
logic/rollback_arbiter.sv
logic/writeback_register.sv
logic/writeback_stage.sv
verif/writeback_checker.sv
verif/writeback_tb.sv

/* logic/load_aligner.sv */
// Forms load results from the data cache line and the store queue bypass
// Purely combinational; feeds the rollback arbiter and the writeback register
`timescale 1ns/1ps

module load_aligner(
	input writeback_pkg::dd_retire_t dd,
	input writeback_pkg::cache_line_u load_line,
	input writeback_pkg::sq_bypass_t sq,
	output writeback_pkg::scalar_t scalar_load,
	output writeback_pkg::vector_t block_load);

	import writeback_pkg::*;

	cache_line_u merged_line;
	scalar_t line_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;

	// Reverse byte order of one word
	function automatic scalar_t swap_bytes(input scalar_t word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// Stores not yet written to the cache win over the line data
	always_comb
	begin
		for (int i = 0; i < CACHE_LINE_BYTES; i++)
		begin
			if (sq.byte_mask[i])
				merged_line.bytes[i] = sq.data.bytes[i];
			else
				merged_line.bytes[i] = load_line.bytes[i];
		end
	end

	// Memory word w is slot 15 - w, which is the bitwise inverse of w
	assign line_word = merged_line.words[~dd.offset[5:2]];

	// Lowest address is the top byte of the slot
	always_comb
	begin
		case (dd.offset[1:0])
			2'd0: byte_aligned = line_word[31:24];
			2'd1: byte_aligned = line_word[23:16];
			2'd2: byte_aligned = line_word[15:8];
			default: byte_aligned = line_word[7:0];
		endcase
	end

	// Halfwords are little endian in memory
	always_comb
	begin
		if (dd.offset[1])
			half_aligned = {line_word[7:0], line_word[15:8]};
		else
			half_aligned = {line_word[23:16], line_word[31:24]};
	end

	// Width select and extension
	always_comb
	begin
		case (dd.instr.mem_op)
			MEM_B: scalar_load = {24'd0, byte_aligned};
			MEM_BX: scalar_load = {{24{byte_aligned[7]}}, byte_aligned};
			MEM_S: scalar_load = {16'd0, half_aligned};
			MEM_SX: scalar_load = {{16{half_aligned[15]}}, half_aligned};
			// Full word, also used when the op is a block load
			default: scalar_load = swap_bytes(line_word);
		endcase
	end

	// Lane L gets memory word 15 - L, which is slot L
	always_comb
	begin
		for (int lane = 0; lane < VECTOR_LANES; lane++)
			block_load[lane] = swap_bytes(merged_line.words[lane]);
	end

endmodule

/* logic/rollback_arbiter.sv */
// Chooses the one rollback and fault raised by the retiring instruction
// Combinational so the rest of the core can squash in the same cycle
`timescale 1ns/1ps

module rollback_arbiter(
	input writeback_pkg::sx_retire_t sx,
	input writeback_pkg::dd_retire_t dd,
	input writeback_pkg::scalar_t scalar_load,
	input logic sq_full_rollback,
	output writeback_pkg::rollback_t rollback,
	output writeback_pkg::fault_t fault);

	import writeback_pkg::*;

	logic sx_writes_pc;
	logic dd_writes_pc;

	// Scalar destination of PC turns an instruction into a jump
	assign sx_writes_pc = sx.instr.has_dest && !sx.instr.dest_is_vector
		&& sx.instr.dest_reg == register_idx_t'(REG_PC);
	assign dd_writes_pc = dd.instr.has_dest && !dd.instr.dest_is_vector
		&& dd.instr.dest_reg == register_idx_t'(REG_PC);

	always_comb
	begin
		// Nothing retiring means no rollback
		rollback = '0;
		fault = '0;

		if (sx.valid && sx.instr.illegal)
		begin
			// Illegal instruction fault
			rollback.en = 1'b1;
			rollback.thread = sx.thread;
			rollback.pc = scalar_t'(FAULT_VECTOR_PC);
			rollback.pipeline = PIPE_SCYCLE_ARITH;
			fault.en = 1'b1;
			fault.reason = FR_ILLEGAL_INSTRUCTION;
			fault.address = sx.instr.pc;
		end
		else if (dd.valid && dd.access_fault)
		begin
			// Bad memory access
			rollback.en = 1'b1;
			rollback.thread = dd.thread;
			rollback.pc = scalar_t'(FAULT_VECTOR_PC);
			rollback.pipeline = PIPE_MEM;
			fault.en = 1'b1;
			fault.reason = FR_INVALID_ACCESS;
			fault.address = dd.instr.pc;
		end
		else if (sx.valid && sx_writes_pc)
		begin
			// Arithmetic result becomes the new PC
			rollback.en = 1'b1;
			rollback.thread = sx.thread;
			rollback.pc = sx.result[0];
			rollback.pipeline = PIPE_SCYCLE_ARITH;
		end
		else if (dd.valid && dd_writes_pc && !dd.rollback_en)
		begin
			// Load to PC, only when the load itself hit
			rollback.en = 1'b1;
			rollback.thread = dd.thread;
			rollback.pc = scalar_load;
			rollback.pipeline = PIPE_MEM;
		end
		else if (sx.valid)
		begin
			// Branch taken
			rollback.en = sx.rollback_en;
			rollback.thread = sx.thread;
			rollback.pc = sx.rollback_pc;
			rollback.pipeline = PIPE_SCYCLE_ARITH;
			rollback.subcycle = sx.subcycle;
		end
		else if (dd.valid)
		begin
			// Cache miss or store queue full, retry the instruction
			rollback.en = dd.rollback_en || sq_full_rollback;
			rollback.thread = dd.thread;
			rollback.pc = dd.rollback_pc;
			rollback.pipeline = PIPE_MEM;
			rollback.subcycle = dd.subcycle;
		end
	end

endmodule

/* logic/writeback_pkg.sv */
// Shared constants and types for the writeback stage and its testbench
// Every RTL file imports this package inside its module body
package writeback_pkg;

	// Core geometry
	localparam int VECTOR_LANES = 16;
	localparam int THREADS = 4;
	localparam int CACHE_LINE_BYTES = 64;
	localparam int CACHE_LINE_WORDS = CACHE_LINE_BYTES / 4;

	// Scalar register 31 is the program counter
	localparam int REG_PC = 31;

	// All faults jump here
	localparam int FAULT_VECTOR_PC = 4;

	typedef logic [31:0] scalar_t;
	// Lane 0 sits in the least significant bits
	typedef scalar_t [VECTOR_LANES - 1:0] vector_t;
	typedef logic [VECTOR_LANES - 1:0] lane_mask_t;
	typedef logic [$clog2(THREADS) - 1:0] thread_idx_t;
	typedef logic [4:0] register_idx_t;
	typedef logic [3:0] subcycle_t;
	typedef logic [$clog2(CACHE_LINE_BYTES) - 1:0] line_offset_t;

	// One cache line, seen as bytes for the bypass merge and as words for the load
	// Memory word w lives in word slot 15 - w, big end first
	typedef union packed
	{
		logic [CACHE_LINE_BYTES - 1:0][7:0] bytes;
		scalar_t [CACHE_LINE_WORDS - 1:0] words;
	} cache_line_u;

	// Load width and extension
	typedef enum logic [2:0]
	{
		MEM_B = 3'd0,
		MEM_BX = 3'd1,
		MEM_S = 3'd2,
		MEM_SX = 3'd3,
		MEM_L = 3'd4,
		MEM_BLOCK = 3'd5
	} mem_op_t;

	typedef enum logic
	{
		PIPE_SCYCLE_ARITH = 1'b0,
		PIPE_MEM = 1'b1
	} pipeline_sel_t;

	typedef enum logic [1:0]
	{
		FR_NONE = 2'd0,
		FR_ILLEGAL_INSTRUCTION = 2'd1,
		FR_INVALID_ACCESS = 2'd2
	} fault_reason_t;

	// Fields of the decoded instruction that writeback cares about
	typedef struct packed
	{
		scalar_t pc;
		logic illegal;
		logic has_dest;
		register_idx_t dest_reg;
		logic dest_is_vector;
		logic is_compare;
		logic is_call;
		logic is_load;
		mem_op_t mem_op;
		subcycle_t last_subcycle;
	} decoded_instr_t;

	// Retiring instruction from the single-cycle arithmetic pipeline
	typedef struct packed
	{
		logic valid;
		decoded_instr_t instr;
		thread_idx_t thread;
		vector_t result;
		lane_mask_t mask;
		logic rollback_en;
		scalar_t rollback_pc;
		subcycle_t subcycle;
	} sx_retire_t;

	// Retiring instruction from the memory pipeline
	typedef struct packed
	{
		logic valid;
		decoded_instr_t instr;
		thread_idx_t thread;
		lane_mask_t lane_mask;
		line_offset_t offset;
		subcycle_t subcycle;
		logic rollback_en;
		scalar_t rollback_pc;
		logic access_fault;
	} dd_retire_t;

	// Pending store data that overrides the cache line
	typedef struct packed
	{
		logic [CACHE_LINE_BYTES - 1:0] byte_mask;
		cache_line_u data;
		logic full_rollback;
	} sq_bypass_t;

	typedef struct packed
	{
		logic en;
		thread_idx_t thread;
		scalar_t pc;
		pipeline_sel_t pipeline;
		subcycle_t subcycle;
	} rollback_t;

	typedef struct packed
	{
		logic en;
		fault_reason_t reason;
		scalar_t address;
	} fault_t;

	// Register file write port
	typedef struct packed
	{
		logic en;
		thread_idx_t thread;
		logic is_vector;
		vector_t value;
		lane_mask_t mask;
		register_idx_t reg_idx;
		logic is_last_subcycle;
	} writeback_t;

endpackage

/* logic/writeback_register.sv */
// Picks the result of the retiring instruction and registers the register file write
// The write appears one clock after the instruction retires
`timescale 1ns/1ps

module writeback_register(
	input clk,
	input reset,
	input writeback_pkg::sx_retire_t sx,
	input writeback_pkg::dd_retire_t dd,
	input logic rollback_en,
	input writeback_pkg::scalar_t scalar_load,
	input writeback_pkg::vector_t block_load,
	output writeback_pkg::writeback_t writeback);

	import writeback_pkg::*;

	lane_mask_t compare_bits;
	writeback_t wb_next;

	// Compare result is bit 0 of each lane
	always_comb
	begin
		for (int lane = 0; lane < VECTOR_LANES; lane++)
			compare_bits[lane] = sx.result[lane][0];
	end

	always_comb
	begin
		wb_next = '0;
		if (sx.valid)
		begin
			// A call writes the link register even though it rolls back
			wb_next.en = sx.instr.is_call || (sx.instr.has_dest && !rollback_en);
			wb_next.thread = sx.thread;
			wb_next.is_vector = sx.instr.dest_is_vector;
			if (sx.instr.is_compare)
				wb_next.value[0] = scalar_t'(compare_bits);
			else
				wb_next.value = sx.result;

			wb_next.mask = sx.mask;
			wb_next.reg_idx = sx.instr.dest_reg;
			wb_next.is_last_subcycle = sx.subcycle == sx.instr.last_subcycle;
		end
		else if (dd.valid)
		begin
			// Miss or queue full squashes the write
			wb_next.en = dd.instr.has_dest && !rollback_en;
			wb_next.thread = dd.thread;
			wb_next.is_vector = dd.instr.dest_is_vector;
			if (dd.instr.is_load && dd.instr.mem_op == MEM_BLOCK)
			begin
				wb_next.value = block_load;
				wb_next.mask = dd.lane_mask;
			end
			else
			begin
				// Scalar load goes to every lane
				wb_next.value = {VECTOR_LANES{scalar_load}};
				wb_next.mask = '1;
			end

			wb_next.reg_idx = dd.instr.dest_reg;
			wb_next.is_last_subcycle = dd.subcycle == dd.instr.last_subcycle;
		end
	end

	// Register file write port
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			writeback <= '0;
		else
			writeback <= wb_next;
	end

endmodule

/* logic/writeback_stage.sv */
// Writeback stage top level
// Load formation and rollback are combinational, the register file write is registered
`timescale 1ns/1ps

module writeback_stage(
	input clk,
	input reset,
	input writeback_pkg::sx_retire_t sx,
	input writeback_pkg::dd_retire_t dd,
	input writeback_pkg::cache_line_u load_line,
	input writeback_pkg::sq_bypass_t sq,
	output writeback_pkg::rollback_t rollback,
	output writeback_pkg::fault_t fault,
	output writeback_pkg::writeback_t writeback);

	import writeback_pkg::*;

	// Aligned load values
	scalar_t scalar_load;
	vector_t block_load;

	load_aligner load_aligner(
		.dd(dd),
		.load_line(load_line),
		.sq(sq),
		.scalar_load(scalar_load),
		.block_load(block_load));

	// Load to PC needs the aligned value
	rollback_arbiter rollback_arbiter(
		.sx(sx),
		.dd(dd),
		.scalar_load(scalar_load),
		.sq_full_rollback(sq.full_rollback),
		.rollback(rollback),
		.fault(fault));

	// Rolled back instructions do not write, except calls
	writeback_register writeback_register(
		.clk(clk),
		.reset(reset),
		.sx(sx),
		.dd(dd),
		.rollback_en(rollback.en),
		.scalar_load(scalar_load),
		.block_load(block_load),
		.writeback(writeback));

endmodule

/* run.sh */
#!/bin/sh
# Builds the writeback stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module writeback_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vwriteback_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	echo "Run passed"
	exit 0
fi
echo "Run failed"
exit 1

/* verif/writeback_checker.sv */
// Concurrent assertions on the writeback stage ports
// Bound into writeback_stage, failures report through $error
`timescale 1ns/1ps

module writeback_checker(
	input logic clk,
	input logic reset,
	input writeback_pkg::sx_retire_t sx,
	input writeback_pkg::dd_retire_t dd,
	input writeback_pkg::sq_bypass_t sq,
	input writeback_pkg::rollback_t rollback,
	input writeback_pkg::fault_t fault,
	input writeback_pkg::writeback_t writeback);

	// Upstream retires one instruction per cycle
	one_retire: assert property (@(posedge clk) disable iff (reset) !(sx.valid && dd.valid))
		else $error("sx and dd valid in the same cycle");

	// Store queue full only means something for a memory op
	sq_full_with_dd: assert property (@(posedge clk) disable iff (reset)
		sq.full_rollback |-> dd.valid)
		else $error("store queue full rollback without a memory op");

	// Register file stays quiet in reset
	no_write_in_reset: assert property (@(posedge clk) reset |-> !writeback.en)
		else $error("register write during reset");

	// Every fault redirects the thread
	fault_rolls_back: assert property (@(posedge clk) disable iff (reset) fault.en |-> rollback.en)
		else $error("fault without rollback");

endmodule

bind writeback_stage writeback_checker checks(
	.clk(clk),
	.reset(reset),
	.sx(sx),
	.dd(dd),
	.sq(sq),
	.rollback(rollback),
	.fault(fault),
	.writeback(writeback));

/* verif/writeback_tb.sv */
// Directed testbench for the writeback stage
// Drives both retire ports on the falling edge, checks rollback and fault in the same cycle
// and the register file write one clock later
`timescale 1ns/1ps

module writeback_tb;

	import writeback_pkg::*;

	logic clk;
	logic reset;
	sx_retire_t sx;
	dd_retire_t dd;
	cache_line_u load_line;
	sq_bypass_t sq;
	rollback_t rollback;
	fault_t fault;
	writeback_t writeback;

	// Random stimulus state
	int seed;

	writeback_stage DUT(
		.clk(clk),
		.reset(reset),
		.sx(sx),
		.dd(dd),
		.load_line(load_line),
		.sq(sq),
		.rollback(rollback),
		.fault(fault),
		.writeback(writeback));

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	task automatic report_failure();
		$display("*** FAILED ***");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic compare_rollback(input rollback_t expected);
		if (rollback !== expected)
		begin
			$display("error rollback: expected %h, got %h", expected, rollback);
			report_failure();
		end
	endtask

	task automatic compare_fault(input fault_t expected);
		if (fault !== expected)
		begin
			$display("error fault: expected %h, got %h", expected, fault);
			report_failure();
		end
	endtask

	// Payload is only meaningful with the enable set
	task automatic compare_writeback(input writeback_t expected);
		if (!expected.en)
		begin
			if (writeback.en !== 1'b0)
			begin
				$display("error writeback.en: expected %h, got %h", expected.en,
					writeback.en);
				report_failure();
			end
		end
		else if (writeback !== expected)
		begin
			$display("error writeback: expected %h, got %h", expected, writeback);
			report_failure();
		end
	endtask

	task automatic idle_inputs();
		sx = '0;
		dd = '0;
		load_line = '0;
		sq = '0;
	endtask

	task automatic random_line(output cache_line_u line);
		for (int i = 0; i < CACHE_LINE_WORDS; i++)
			line.words[i] = $random(seed);
	endtask

	// Store queue bytes replace line bytes where the mask is set
	function automatic cache_line_u merge_line(input cache_line_u line,
		input sq_bypass_t bypass);
		cache_line_u merged;
		merged = line;
		for (int i = 0; i < CACHE_LINE_BYTES; i++)
		begin
			if (bypass.byte_mask[i])
				merged.bytes[i] = bypass.data.bytes[i];
		end
		return merged;
	endfunction

	// Memory word w sits in slot 15 - w, lowest address in the top byte
	function automatic logic [7:0] memory_byte(input cache_line_u line,
		input line_offset_t addr);
		scalar_t slot;
		logic [3:0] slot_idx;
		logic [1:0] byte_pos;
		slot_idx = 4'd15 - addr[5:2];
		byte_pos = 2'd3 - addr[1:0];
		slot = line.words[slot_idx];
		return slot[{byte_pos, 3'b000} +: 8];
	endfunction

	// Little endian word at memory word index w
	function automatic scalar_t memory_word(input cache_line_u line, input logic [3:0] w);
		return {memory_byte(line, {w, 2'd3}), memory_byte(line, {w, 2'd2}),
			memory_byte(line, {w, 2'd1}), memory_byte(line, {w, 2'd0})};
	endfunction

	function automatic scalar_t expected_load(input cache_line_u line, input line_offset_t offset,
		input mem_op_t op);
		logic [7:0] byte_val;
		logic [15:0] half_val;
		scalar_t result;
		byte_val = memory_byte(line, offset);
		// Halfword is little endian at offset bit 1
		half_val = {memory_byte(line, {offset[5:1], 1'b1}),
			memory_byte(line, {offset[5:1], 1'b0})};
		case (op)
			MEM_B: result = {24'd0, byte_val};
			MEM_BX: result = {{24{byte_val[7]}}, byte_val};
			MEM_S: result = {16'd0, half_val};
			MEM_SX: result = {{16{half_val[15]}}, half_val};
			default: result = memory_word(line, offset[5:2]);
		endcase
		return result;
	endfunction

	// Rollback of a load that hits, carried but not enabled
	function automatic rollback_t plain_load_rollback(input dd_retire_t req);
		rollback_t rb;
		rb = '0;
		rb.thread = req.thread;
		rb.pc = req.rollback_pc;
		rb.pipeline = PIPE_MEM;
		rb.subcycle = req.subcycle;
		return rb;
	endfunction

	task automatic setup_sx(input thread_idx_t thread, input register_idx_t dest_reg,
		input logic dest_is_vector);
		sx = '0;
		sx.valid = 1'b1;
		sx.instr.pc = $random(seed);
		sx.instr.has_dest = 1'b1;
		sx.instr.dest_reg = dest_reg;
		sx.instr.dest_is_vector = dest_is_vector;
		sx.instr.last_subcycle = 4'd2;
		sx.thread = thread;
		for (int lane = 0; lane < VECTOR_LANES; lane++)
			sx.result[lane] = $random(seed);
		sx.mask = lane_mask_t'($random(seed));
		sx.rollback_pc = $random(seed);
		sx.subcycle = 4'd2;
	endtask

	// Random line and bypass, load at the given offset
	task automatic setup_load(input mem_op_t op, input line_offset_t offset,
		input thread_idx_t thread, input register_idx_t dest_reg, input logic dest_is_vector);
		dd = '0;
		dd.valid = 1'b1;
		dd.instr.pc = $random(seed);
		dd.instr.has_dest = 1'b1;
		dd.instr.dest_reg = dest_reg;
		dd.instr.dest_is_vector = dest_is_vector;
		dd.instr.is_load = 1'b1;
		dd.instr.mem_op = op;
		dd.thread = thread;
		dd.lane_mask = lane_mask_t'($random(seed));
		dd.offset = offset;
		dd.rollback_pc = $random(seed);
		random_line(load_line);
		random_line(sq.data);
		sq.byte_mask = {$random(seed), $random(seed)};
		sq.full_rollback = 1'b0;
	endtask

	// Checks the retire cycle, then waits for the register write
	task automatic check_retire(input rollback_t exp_rb, input fault_t exp_fault,
		input writeback_t exp_wb);
		int cycles;
		int limit;
		#10;
		compare_rollback(exp_rb);
		compare_fault(exp_fault);
		limit = exp_wb.en ? 8 : 1;
		cycles = 0;
		while (cycles < limit)
		begin
			@(negedge clk);
			cycles++;
			if (cycles == 1)
				idle_inputs();
			if (writeback.en)
				break;
		end
		if (exp_wb.en && !writeback.en)
		begin
			$display("Timed out waiting for the register file write");
			report_failure();
		end
		if (cycles != 1)
		begin
			$display("Register file write came %0d cycles after retire instead of 1", cycles);
			report_failure();
		end
		compare_writeback(exp_wb);
	endtask

	// An instruction retiring during reset must not reach the register file
	task automatic test_after_reset();
		setup_sx(2'd0, 5'd1, 1'b0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle_inputs();
		#10;
		compare_rollback('0);
		compare_fault('0);
		compare_writeback('0);
		@(negedge clk);
	endtask

	task automatic test_sx_arith();
		rollback_t exp_rb;
		writeback_t exp_wb;
		setup_sx(2'd2, 5'd7, 1'b1);
		exp_rb = '0;
		exp_rb.thread = 2'd2;
		exp_rb.pc = sx.rollback_pc;
		exp_rb.pipeline = PIPE_SCYCLE_ARITH;
		exp_rb.subcycle = 4'd2;
		exp_wb = '0;
		exp_wb.en = 1'b1;
		exp_wb.thread = 2'd2;
		exp_wb.is_vector = 1'b1;
		exp_wb.value = sx.result;
		exp_wb.mask = sx.mask;
		exp_wb.reg_idx = 5'd7;
		exp_wb.is_last_subcycle = 1'b1;
		check_retire(exp_rb, '0, exp_wb);
	endtask

	// Bit 0 of each lane packs into lane 0
	task automatic test_sx_compare();
		rollback_t exp_rb;
		writeback_t exp_wb;
		lane_mask_t bits;
		setup_sx(2'd1, 5'd9, 1'b0);
		sx.instr.is_compare = 1'b1;
		sx.instr.last_subcycle = 4'd5;
		for (int lane = 0; lane < VECTOR_LANES; lane++)
			bits[lane] = sx.result[lane][0];
		exp_rb = '0;
		exp_rb.thread = 2'd1;
		exp_rb.pc = sx.rollback_pc;
		exp_rb.subcycle = 4'd2;
		exp_wb = '0;
		exp_wb.en = 1'b1;
		exp_wb.thread = 2'd1;
		exp_wb.value[0] = {16'd0, bits};
		exp_wb.mask = sx.mask;
		exp_wb.reg_idx = 5'd9;
		check_retire(exp_rb, '0, exp_wb);
	endtask

	// Call jumps away but still writes the link register
	task automatic test_call_link();
		rollback_t exp_rb;
		writeback_t exp_wb;
		setup_sx(2'd3, 5'd30, 1'b0);
		sx.instr.is_call = 1'b1;
		sx.rollback_en = 1'b1;
		exp_rb = '0;
		exp_rb.en = 1'b1;
		exp_rb.thread = 2'd3;
		exp_rb.pc = sx.rollback_pc;
		exp_rb.subcycle = 4'd2;
		exp_wb = '0;
		exp_wb.en = 1'b1;
		exp_wb.thread = 2'd3;
		exp_wb.value = sx.result;
		exp_wb.mask = sx.mask;
		exp_wb.reg_idx = 5'd30;
		exp_wb.is_last_subcycle = 1'b1;
		check_retire(exp_rb, '0, exp_wb);
	endtask

	// Every scalar width at every byte offset
	task automatic test_scalar_loads();
		mem_op_t scalar_ops[5];
		writeback_t exp_wb;
		scalar_t value;
		scalar_ops = '{MEM_B, MEM_BX, MEM_S, MEM_SX, MEM_L};
		for (int k = 0; k < 5; k++)
		begin
			for (int offset = 0; offset < CACHE_LINE_BYTES; offset++)
			begin
				setup_load(scalar_ops[k], line_offset_t'(offset), 2'd1, 5'd3, 1'b0);
				value = expected_load(merge_line(load_line, sq), dd.offset, scalar_ops[k]);
				exp_wb = '0;
				exp_wb.en = 1'b1;
				exp_wb.thread = 2'd1;
				for (int lane = 0; lane < VECTOR_LANES; lane++)
					exp_wb.value[lane] = value;
				exp_wb.mask = '1;
				exp_wb.reg_idx = 5'd3;
				exp_wb.is_last_subcycle = 1'b1;
				check_retire(plain_load_rollback(dd), '0, exp_wb);
			end
		end
	endtask

	// Lane L gets memory word 15 - L
	task automatic test_block_loads();
		cache_line_u merged;
		writeback_t exp_wb;
		logic [3:0] word_idx;
		for (int iter = 0; iter < 4; iter++)
		begin
			setup_load(MEM_BLOCK, 6'd0, thread_idx_t'(iter), 5'd12, 1'b1);
			merged = merge_line(load_line, sq);
			exp_wb = '0;
			exp_wb.en = 1'b1;
			exp_wb.thread = thread_idx_t'(iter);
			exp_wb.is_vector = 1'b1;
			for (int lane = 0; lane < VECTOR_LANES; lane++)
			begin
				word_idx = 4'd15 - lane[3:0];
				exp_wb.value[lane] = memory_word(merged, word_idx);
			end
			exp_wb.mask = dd.lane_mask;
			exp_wb.reg_idx = 5'd12;
			exp_wb.is_last_subcycle = 1'b1;
			check_retire(plain_load_rollback(dd), '0, exp_wb);
		end
	endtask

	// Illegal beats the branch the same instruction asks for
	task automatic test_illegal_fault();
		rollback_t exp_rb;
		fault_t exp_fault;
		setup_sx(2'd3, 5'd5, 1'b1);
		sx.instr.illegal = 1'b1;
		sx.rollback_en = 1'b1;
		exp_rb = '0;
		exp_rb.en = 1'b1;
		exp_rb.thread = 2'd3;
		exp_rb.pc = scalar_t'(FAULT_VECTOR_PC);
		exp_rb.pipeline = PIPE_SCYCLE_ARITH;
		exp_fault = '0;
		exp_fault.en = 1'b1;
		exp_fault.reason = FR_ILLEGAL_INSTRUCTION;
		exp_fault.address = sx.instr.pc;
		check_retire(exp_rb, exp_fault, '0);
	endtask

	task automatic test_access_fault();
		rollback_t exp_rb;
		fault_t exp_fault;
		setup_load(MEM_L, 6'd16, 2'd2, 5'd6, 1'b0);
		dd.access_fault = 1'b1;
		dd.rollback_en = 1'b1;
		exp_rb = '0;
		exp_rb.en = 1'b1;
		exp_rb.thread = 2'd2;
		exp_rb.pc = scalar_t'(FAULT_VECTOR_PC);
		exp_rb.pipeline = PIPE_MEM;
		exp_fault = '0;
		exp_fault.en = 1'b1;
		exp_fault.reason = FR_INVALID_ACCESS;
		exp_fault.address = dd.instr.pc;
		check_retire(exp_rb, exp_fault, '0);
	endtask

	// Writes to PC jump and suppress the register write
	task automatic test_pc_writes();
		rollback_t exp_rb;
		setup_sx(2'd1, register_idx_t'(REG_PC), 1'b0);
		exp_rb = '0;
		exp_rb.en = 1'b1;
		exp_rb.thread = 2'd1;
		exp_rb.pc = sx.result[0];
		exp_rb.pipeline = PIPE_SCYCLE_ARITH;
		check_retire(exp_rb, '0, '0);
		setup_load(MEM_L, line_offset_t'($random(seed)), 2'd0, register_idx_t'(REG_PC), 1'b0);
		exp_rb = '0;
		exp_rb.en = 1'b1;
		exp_rb.pc = expected_load(merge_line(load_line, sq), dd.offset, MEM_L);
		exp_rb.pipeline = PIPE_MEM;
		check_retire(exp_rb, '0, '0);
	endtask

	task automatic test_sq_full();
		rollback_t exp_rb;
		setup_load(MEM_B, 6'd9, 2'd3, 5'd4, 1'b0);
		sq.full_rollback = 1'b1;
		dd.subcycle = 4'd2;
		exp_rb = plain_load_rollback(dd);
		exp_rb.en = 1'b1;
		check_retire(exp_rb, '0, '0);
	endtask

	initial
	begin
		seed = 32'h161;
		reset = 1'b1;
		idle_inputs();
		test_after_reset();
		test_sx_arith();
		test_sx_compare();
		test_call_link();
		test_scalar_loads();
		test_block_loads();
		test_illegal_fault();
		test_access_fault();
		test_pc_writes();
		test_sq_full();
		$display("*** PASSED ***");
		$finish;
	end

endmodule
